// ==== list.f ====
+incdir+source
+incdir+tests
source/sm3_expnd_pkg.sv
source/sm3_expnd_ctrl.sv
source/sm3_word_buff.sv
source/sm3_expnd_top.sv
tests/tb_sm3_expnd.sv

// ==== run.sh ====
#!/bin/sh
# build and run the SM3 message expansion testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_sm3_expnd
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

exit 0

// ==== source/sm3_expnd_ctrl.sv ====
`include "sm3_params.svh"

module sm3_expnd_ctrl (
    input  logic clk,
    input  logic rst_n,

    // message word handshake
    input  logic pad_vld_i,
    input  logic pad_lst_i,
    output logic pad_rdy_o,

    // word buffer control
    output logic shift_en_o,
    output logic push_expnd_o,

    // output strobes
    output logic expnd_vld_o,
    output logic expnd_lst_o
);
    import sm3_expnd_pkg::*;

    localparam word_cnt_t  LOAD_LAST  = word_cnt_t'(`SM3_LOAD_WORDS - 1);
    localparam word_cnt_t  BLK_LAST   = word_cnt_t'(`SM3_BLK_WORDS - 1);
    localparam round_cnt_t ROUND_LAST = round_cnt_t'(`SM3_EXPND_ROUNDS - 1);

    expnd_state_e state_q;
    expnd_state_e state_d;

    word_cnt_t    word_cnt_q;     // accepted words in this block
    round_cnt_t   round_cnt_q;    // expansion cycles done
    logic         lst_flg_q;      // block belongs to the last message

    logic         pad_xfer;
    logic         load_done;
    logic         blk_done;
    logic         round_last;
    logic         in_expand;

    //////////////////////////////////////////////////////////////////////
    // handshake decode
    //////////////////////////////////////////////////////////////////////

    assign in_expand  = (state_q == EXPAND);
    assign pad_rdy_o  = !in_expand;                 // input closed while expanding
    assign pad_xfer   = pad_vld_i && pad_rdy_o;

    assign load_done  = (word_cnt_q == LOAD_LAST);  // w4 arriving
    assign blk_done   = (word_cnt_q == BLK_LAST);   // w15 arriving
    assign round_last = (round_cnt_q == ROUND_LAST);

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOAD: begin
                if (pad_xfer && load_done) begin
                    state_d = STREAM;
                end
            end
            STREAM: begin
                if (pad_xfer && blk_done) begin
                    state_d = EXPAND;
                end
            end
            EXPAND: begin
                if (round_last) begin
                    state_d = LOAD;   // input reopens next cycle
                end
            end
            default: begin
                state_d = LOAD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LOAD;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////////

    // input words wrap to zero after w15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt_q <= '0;
        end else if (pad_xfer) begin
            if (blk_done) begin
                word_cnt_q <= '0;
            end else begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    // expansion rounds move only in EXPAND
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_cnt_q <= '0;
        end else if (in_expand) begin
            if (round_last) begin
                round_cnt_q <= '0;
            end else begin
                round_cnt_q <= round_cnt_q + 1'b1;
            end
        end
    end

    // last-block flag set by any marked word and cleared by the j = 63 strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst_flg_q <= 1'b0;
        end else if (pad_xfer && pad_lst_i) begin
            lst_flg_q <= 1'b1;
        end else if (expnd_lst_o) begin
            lst_flg_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // buffer control and strobes
    //////////////////////////////////////////////////////////////////////

    assign shift_en_o   = pad_xfer || in_expand;
    assign push_expnd_o = in_expand;                  // feed back W(j+16)

    // in STREAM the pair leaves with the word that pushes it along
    assign expnd_vld_o  = ((state_q == STREAM) && pad_xfer) || in_expand;
    assign expnd_lst_o  = lst_flg_q && in_expand && round_last;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_round_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        round_cnt_q <= ROUND_LAST
    );

    // the last pair ends the block and drops the flag
    a_lst_closes_blk : assert property (
        @(posedge clk) disable iff (!rst_n)
        expnd_lst_o |=> (!lst_flg_q && (state_q == LOAD))
    );

    // no word gets counted during the expansion run
    a_no_xfer_expand : assert property (
        @(posedge clk) disable iff (!rst_n)
        in_expand |=> $stable(word_cnt_q)
    );

endmodule

// ==== source/sm3_expnd_pkg.sv ====
`include "sm3_params.svh"

package sm3_expnd_pkg;

    //////////////////////////////////////////////////////////////////////
    // plain vectors
    //////////////////////////////////////////////////////////////////////

    // one message or expanded word
    typedef logic [`SM3_WORD_W-1:0] word_t;

    // input words within a block, 0..15
    typedef logic [$clog2(`SM3_BLK_WORDS)-1:0] word_cnt_t;

    // expansion rounds within a block, 0..52
    typedef logic [$clog2(`SM3_EXPND_ROUNDS)-1:0] round_cnt_t;

    //////////////////////////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        LOAD   = 2'd0,  // taking w0..w4, nothing out yet
        STREAM = 2'd1,  // taking w5..w15, one pair out per word
        EXPAND = 2'd2   // input closed, one expansion per cycle
    } expnd_state_e;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    // padded message word plus last-block marker
    typedef struct packed {
        logic  lst;
        word_t data;
    } pad_word_t;

    // expanded output pair
    typedef struct packed {
        word_t wj;      // W(j)
        word_t wjj;     // W'(j) = W(j) ^ W(j+4)
    } expnd_pair_t;

endpackage

// ==== source/sm3_expnd_top.sv ====
module sm3_expnd_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // padded message input, valid/ready
    input  sm3_expnd_pkg::pad_word_t   pad_i,
    input  logic                       pad_vld_i,
    output logic                       pad_rdy_o,

    // expanded pairs, strobe without back-pressure
    output sm3_expnd_pkg::expnd_pair_t expnd_o,
    output logic                       expnd_vld_o,
    output logic                       expnd_lst_o
);

    //////////////////////////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////////////////////////

    logic                 shift_en;     // buffer moves one slot
    logic                 push_expnd;   // feedback instead of pad data
    sm3_expnd_pkg::word_t pad_data;
    logic                 pad_lst;

    // split the input bundle
    assign pad_data = pad_i.data;
    assign pad_lst  = pad_i.lst;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    sm3_expnd_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .pad_vld_i    (pad_vld_i),
        .pad_lst_i    (pad_lst),
        .pad_rdy_o    (pad_rdy_o),
        .shift_en_o   (shift_en),
        .push_expnd_o (push_expnd),
        .expnd_vld_o  (expnd_vld_o),
        .expnd_lst_o  (expnd_lst_o)
    );

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    sm3_word_buff u_buff (
        .clk          (clk),
        .rst_n        (rst_n),
        .shift_en_i   (shift_en),
        .push_expnd_i (push_expnd),
        .pad_data_i   (pad_data),
        .pair_o       (expnd_o)
    );

endmodule

// ==== source/sm3_params.svh ====
`ifndef SM3_PARAMS_SVH
`define SM3_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// message word geometry
//////////////////////////////////////////////////////////////////////

// width of one message / expanded word
`define SM3_WORD_W          32

// a padded 512-bit block is sixteen words
`define SM3_BLK_WORDS       16

//////////////////////////////////////////////////////////////////////
// expansion schedule
//////////////////////////////////////////////////////////////////////

// words held before the first pair can leave (w0..w4)
`define SM3_LOAD_WORDS      5

// buffer slot holding W(j), W'(j) also needs slot 15
`define SM3_OUT_TAP         11

// expansion cycles per block, pairs j = 11..63
`define SM3_EXPND_ROUNDS    53

`endif

// ==== source/sm3_word_buff.sv ====
`include "sm3_params.svh"

module sm3_word_buff (
    input  logic                       clk,
    input  logic                       rst_n,

    // shift control from the FSM
    input  logic                       shift_en_i,
    input  logic                       push_expnd_i,

    // incoming message word
    input  sm3_expnd_pkg::word_t       pad_data_i,

    // W(j) / W'(j) taps
    output sm3_expnd_pkg::expnd_pair_t pair_o
);
    import sm3_expnd_pkg::*;

    localparam int unsigned TOP_IDX = `SM3_BLK_WORDS - 1;

    // relative to the word being produced, W(j)
    localparam int unsigned IDX_M16 = 0;    // W(j-16)
    localparam int unsigned IDX_M13 = 3;    // W(j-13)
    localparam int unsigned IDX_M9  = 7;    // W(j-9)
    localparam int unsigned IDX_M6  = 10;   // W(j-6)
    localparam int unsigned IDX_M3  = 13;   // W(j-3)

    word_t buff_q [`SM3_BLK_WORDS];         // slot 0 oldest, slot 15 newest

    word_t p1_in;
    word_t p1_out;
    word_t expnd_word;
    word_t push_word;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t rotl(input word_t x, input int unsigned n);
        rotl = (x << n) | (x >> (`SM3_WORD_W - n));
    endfunction

    // permutation used by the message expansion
    function automatic word_t p1(input word_t x);
        p1 = x ^ rotl(x, 15) ^ rotl(x, 23);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // expansion function
    //////////////////////////////////////////////////////////////////////

    assign p1_in      = buff_q[IDX_M16] ^ buff_q[IDX_M9] ^ rotl(buff_q[IDX_M3], 15);
    assign p1_out     = p1(p1_in);
    assign expnd_word = p1_out ^ rotl(buff_q[IDX_M13], 7) ^ buff_q[IDX_M6];

    // raw message word while loading, feedback while expanding
    assign push_word  = push_expnd_i ? expnd_word : pad_data_i;

    //////////////////////////////////////////////////////////////////////
    // shift buffer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SM3_BLK_WORDS; i++) begin
                buff_q[i] <= '0;
            end
        end else if (shift_en_i) begin
            // w0 <- w1 ... w14 <- w15
            for (int i = 0; i < TOP_IDX; i++) begin
                buff_q[i] <= buff_q[i + 1];
            end
            buff_q[TOP_IDX] <= push_word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output taps
    //////////////////////////////////////////////////////////////////////

    // slot 11 is W(j), slot 15 four words later is W(j+4)
    assign pair_o.wj  = buff_q[`SM3_OUT_TAP];
    assign pair_o.wjj = buff_q[`SM3_OUT_TAP] ^ buff_q[TOP_IDX];

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // feedback select only means something on a shift
    a_push_needs_shift : assert property (
        @(posedge clk) disable iff (!rst_n)
        push_expnd_i |-> shift_en_i
    );

endmodule

// ==== tests/tb_sm3_model.svh ====
`ifndef TB_SM3_MODEL_SVH
`define TB_SM3_MODEL_SVH

// one expected strobe
typedef struct packed {
    sm3_expnd_pkg::expnd_pair_t pair;
    logic                       lst;    // high only on j = 63 of a last block
} exp_ent_t;

//////////////////////////////////////////////////////////////////////
// random words
//////////////////////////////////////////////////////////////////////

// 32-bit xorshift, shifts 13 / 17 / 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic void fill_rand_block(inout logic [31:0] seed, output word_t w [16]);
    for (int i = 0; i < 16; i++) begin
        seed = xorshift32(seed);
        w[i] = seed;
    end
endfunction

// "abc" after padding, one pad bit and a 24-bit length
function automatic void fill_abc_block(output word_t w [16]);
    for (int i = 0; i < 16; i++) begin
        w[i] = 32'h0;
    end
    w[0]  = 32'h6162_6380;
    w[15] = 32'h0000_0018;
endfunction

//////////////////////////////////////////////////////////////////////
// expansion model
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] rotl32(input logic [31:0] x, input int n);
    logic [63:0] d;
    d = {x, x} << n;    // upper half is the rotated word
    return d[63:32];
endfunction

function automatic logic [31:0] p1_perm(input logic [31:0] x);
    return x ^ rotl32(x, 15) ^ rotl32(x, 23);
endfunction

// W(0..67) from the block, then the 64 pairs in output order
function automatic void expand_block(input word_t m [16], input logic lst,
                                     output exp_ent_t e [64]);
    logic [31:0] w [68];
    for (int j = 0; j < 16; j++) begin
        w[j] = m[j];
    end
    for (int j = 16; j < 68; j++) begin
        w[j] = p1_perm(w[j-16] ^ w[j-9] ^ rotl32(w[j-3], 15))
               ^ rotl32(w[j-13], 7) ^ w[j-6];
    end
    for (int j = 0; j < 64; j++) begin
        e[j].pair.wj  = w[j];
        e[j].pair.wjj = w[j] ^ w[j+4];
        e[j].lst      = lst && (j == 63);
    end
endfunction

`endif

// ==== tests/tb_sm3_expnd.sv ====
`include "sm3_params.svh"

module tb_sm3_expnd;
    import sm3_expnd_pkg::*;

    `include "tb_sm3_model.svh"

    localparam int NUM_BLK      = 6;
    localparam int MAX_GAP      = 3;    // idle cycles before one word
    localparam int BLK_PAIRS    = 64;
    localparam int STREAM_PAIRS = `SM3_BLK_WORDS - `SM3_LOAD_WORDS;   // j = 0..10
    localparam int TIMEOUT      = NUM_BLK * (`SM3_BLK_WORDS + `SM3_BLK_WORDS * MAX_GAP
                                  + `SM3_EXPND_ROUNDS) + 200;

    // one row of the block table
    typedef struct packed {
        logic       use_abc;    // "abc" block or else xorshift words
        logic       lst;        // block carries the last bit
        logic [1:0] gap_max;    // idle cycles before each word up to gap_max
    } blk_cfg_t;

    logic        clk = 1'b0;
    logic        rst_n;
    pad_word_t   pad_i;
    logic        pad_vld_i;
    logic        pad_rdy_o;
    expnd_pair_t expnd_o;
    logic        expnd_vld_o;
    logic        expnd_lst_o;

    blk_cfg_t    blk_tab [NUM_BLK];
    word_t       blk_words [NUM_BLK][16];
    int          gap_cnt [NUM_BLK][16];
    exp_ent_t    exp_q [$];
    logic [31:0] rnd_state;
    int          cycle_cnt  = 0;
    int          strobe_cnt = 0;
    int          pair_j     = 0;    // next expected j within the block
    logic        reopen_chk = 1'b0;

    sm3_expnd_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pad_i       (pad_i),
        .pad_vld_i   (pad_vld_i),
        .pad_rdy_o   (pad_rdy_o),
        .expnd_o     (expnd_o),
        .expnd_vld_o (expnd_vld_o),
        .expnd_lst_o (expnd_lst_o)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
            abort_run();
        end
    endtask

    // gap cycles first, then hold the word until it is taken
    task automatic send_word(input word_t data, input logic lst, input int gap);
        repeat (gap) begin
            pad_vld_i  <= 1'b0;
            pad_i.data <= ~data;
            pad_i.lst  <= 1'b1;     // junk marked last that must be ignored
            @(posedge clk);
        end
        pad_vld_i  <= 1'b1;
        pad_i.data <= data;
        pad_i.lst  <= lst;
        @(negedge clk);
        while (!pad_rdy_o) begin
            @(negedge clk);
        end
        @(posedge clk);             // word accepted here
    endtask

    //////////////////////////////////////////////////////////////////////
    // timeout and output monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    always @(negedge clk) begin : monitor
        exp_ent_t e;
        if (rst_n) begin
            if (reopen_chk) begin
                check_value("pad_rdy_o", 64'(pad_rdy_o), 64'd1);   // back in LOAD
                reopen_chk = 1'b0;
            end
            if (expnd_vld_o) begin
                if (exp_q.size() == 0) begin
                    $display("output strobe seen with no pair left to expect");
                    abort_run();
                end else begin
                    e = exp_q.pop_front();
                    check_value("expnd_o.wj", 64'(expnd_o.wj), 64'(e.pair.wj));
                    check_value("expnd_o.wjj", 64'(expnd_o.wjj), 64'(e.pair.wjj));
                    check_value("expnd_lst_o", 64'(expnd_lst_o), 64'(e.lst));
                    check_value("pad_rdy_o", 64'(pad_rdy_o), 64'(pair_j < STREAM_PAIRS));
                    strobe_cnt = strobe_cnt + 1;
                    reopen_chk = (pair_j == BLK_PAIRS - 1);
                    pair_j     = (pair_j == BLK_PAIRS - 1) ? 0 : pair_j + 1;
                end
            end else begin
                check_value("expnd_lst_o", 64'(expnd_lst_o), 64'd0);
                if (pair_j >= STREAM_PAIRS) begin
                    // expansion strobes run without a break
                    check_value("expnd_vld_o", 64'(expnd_vld_o), 64'd1);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        word_t    words [16];
        exp_ent_t pairs [64];

        rst_n     = 1'b0;
        pad_vld_i = 1'b0;
        pad_i     = '0;
        rnd_state = 32'h9cca;

        blk_tab = '{
            '{1'b1, 1'b0, 2'd0},    // abc straight through
            '{1'b0, 1'b0, 2'd3},
            '{1'b0, 1'b1, 2'd0},    // last block back to back with the next
            '{1'b0, 1'b0, 2'd0},
            '{1'b0, 1'b0, 2'd2},
            '{1'b1, 1'b1, 2'd3}
        };

        for (int b = 0; b < NUM_BLK; b++) begin
            if (blk_tab[b].use_abc) begin
                fill_abc_block(words);
            end else begin
                fill_rand_block(rnd_state, words);
            end
            for (int i = 0; i < 16; i++) begin
                rnd_state       = xorshift32(rnd_state);
                gap_cnt[b][i]   = int'(rnd_state[7:0]) % (int'(blk_tab[b].gap_max) + 1);
                blk_words[b][i] = words[i];
            end
            expand_block(words, blk_tab[b].lst, pairs);
            foreach (pairs[j]) begin
                exp_q.push_back(pairs[j]);
            end
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("pad_rdy_o", 64'(pad_rdy_o), 64'd1);
        check_value("expnd_vld_o", 64'(expnd_vld_o), 64'd0);
        check_value("expnd_lst_o", 64'(expnd_lst_o), 64'd0);
        @(posedge clk);

        // the last bit rides on word b, so it lands in LOAD or in STREAM
        for (int b = 0; b < NUM_BLK; b++) begin
            for (int i = 0; i < `SM3_BLK_WORDS; i++) begin
                send_word(blk_words[b][i], blk_tab[b].lst && (i == b), gap_cnt[b][i]);
            end
        end
        pad_vld_i <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);     // catch any stray strobe

        if (strobe_cnt == NUM_BLK * BLK_PAIRS) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("** Error at %0t: strobe_cnt = %0d, expected %0d",
                     $time, strobe_cnt, NUM_BLK * BLK_PAIRS);
            abort_run();
        end
    end

endmodule
